/* Makefile */
# Verilator simulation of the peripheral subsystem

BUILD = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f files.f \
		--top-module tb_periph_top -Mdir $(BUILD)
	./$(BUILD)/Vtb_periph_top | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* files.f */
verilog/wb_bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/mtime_timer.sv
verilog/sys_con.sv
verilog/gpio_block.sv
verilog/wb_addr_decode.sv
verilog/periph_top.sv
verif/tb_periph_top.sv

/* verif/tb_periph_top.sv */
// Testbench for the peripheral subsystem
// Applies a table of bus writes, read checks and pin changes, and
// checks the interrupt and GPIO outputs between table runs

`timescale 1ns/1ps
`default_nettype none

module tb_periph_top
   import wb_bus_pkg::*, soc_map_pkg::*;
();

   localparam int      OP_WR        = 0;
   localparam int      OP_RD        = 1;
   localparam int      OP_PIN       = 2;
   localparam int      MAX_ROWS     = 64;
   localparam int      TIMEOUT      = 100;
   localparam wb_adr_t UNMAPPED_ADR = 16'h0200;

   logic    clk;
   logic    i_rst_n;
   wb_adr_t i_wb_adr;
   wb_dat_t i_wb_dat;
   logic    i_wb_we;
   logic    i_wb_cyc;
   logic    i_wb_stb;
   wb_dat_t o_wb_rdt;
   logic    o_wb_ack;
   logic    o_wb_err;
   logic    i_ram_init_done;
   logic    i_ram_init_error;
   logic    o_timer_irq;
   logic    o_sw_irq3;
   logic    o_sw_irq4;
   logic    o_nmi_int;
   wb_dat_t o_nmi_vec;
   gpio_t   i_gpio_in;
   gpio_t   o_gpio_out;
   gpio_t   o_gpio_oe;
   logic    o_gpio_irq;

   // Stimulus table
   int      tab_op  [MAX_ROWS];
   wb_adr_t tab_adr [MAX_ROWS];
   wb_dat_t tab_dat [MAX_ROWS];
   wb_dat_t tab_exp [MAX_ROWS];
   int      n_rows;
   int      next_row;
   int      n_checks;
   int      n_errors;

   periph_top i_periph_top (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_wb_adr         (i_wb_adr),
      .i_wb_dat         (i_wb_dat),
      .i_wb_we          (i_wb_we),
      .i_wb_cyc         (i_wb_cyc),
      .i_wb_stb         (i_wb_stb),
      .o_wb_rdt         (o_wb_rdt),
      .o_wb_ack         (o_wb_ack),
      .o_wb_err         (o_wb_err),
      .i_ram_init_done  (i_ram_init_done),
      .i_ram_init_error (i_ram_init_error),
      .o_timer_irq      (o_timer_irq),
      .o_sw_irq3        (o_sw_irq3),
      .o_sw_irq4        (o_sw_irq4),
      .o_nmi_int        (o_nmi_int),
      .o_nmi_vec        (o_nmi_vec),
      .i_gpio_in        (i_gpio_in),
      .o_gpio_out       (o_gpio_out),
      .o_gpio_oe        (o_gpio_oe),
      .o_gpio_irq       (o_gpio_irq)
   );

   always #5 clk = ~clk;

   function automatic wb_adr_t sys_addr(input reg_ofs_t ofs);
      sys_addr = SYS_BASE | {{(WB_ADR_W-REG_OFS_W){1'b0}}, ofs};
   endfunction

   function automatic wb_adr_t gpio_addr(input reg_ofs_t ofs);
      gpio_addr = GPIO_BASE | {{(WB_ADR_W-REG_OFS_W){1'b0}}, ofs};
   endfunction

   task automatic check(input string name, input wb_dat_t act, input wb_dat_t exp);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("FAIL %0t %s: got %h, expected %h", $time, name, act, exp);
      end
   endtask

   // ********************
   // Bus access
   // ********************

   task automatic bus_xfer(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                           output wb_dat_t rdt, output logic ack, output logic err);
      int cnt;
      @(posedge clk);
      #1;
      i_wb_adr = adr;
      i_wb_dat = dat;
      i_wb_we  = we;
      i_wb_cyc = 1'b1;
      i_wb_stb = 1'b1;
      ack = 1'b0;
      err = 1'b0;
      cnt = 0;
      while (!ack && !err && cnt < TIMEOUT) begin
         @(posedge clk);
         #1;
         ack = o_wb_ack;
         err = o_wb_err;
         cnt++;
      end
      rdt = o_wb_rdt;
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
      i_wb_we  = 1'b0;
      if (!ack && !err) begin
         n_errors++;
         $display("Timeout at %0t: no ack or err from address %h", $time, adr);
      end
   endtask

   task automatic add_row(input int op, input wb_adr_t adr, input wb_dat_t dat,
                          input wb_dat_t exp);
      tab_op[n_rows]  = op;
      tab_adr[n_rows] = adr;
      tab_dat[n_rows] = dat;
      tab_exp[n_rows] = exp;
      n_rows++;
   endtask

   // Applies every row added since the last call
   task automatic run_rows();
      wb_dat_t rdt;
      logic    ack;
      logic    err;
      while (next_row < n_rows) begin
         case (tab_op[next_row])
            OP_WR: begin
               bus_xfer(1'b1, tab_adr[next_row], tab_dat[next_row], rdt, ack, err);
               check($sformatf("o_wb_ack at %h", tab_adr[next_row]), 32'(ack), 32'd1);
            end
            OP_RD: begin
               bus_xfer(1'b0, tab_adr[next_row], '0, rdt, ack, err);
               check($sformatf("o_wb_ack at %h", tab_adr[next_row]), 32'(ack), 32'd1);
               check($sformatf("o_wb_rdt at %h", tab_adr[next_row]), rdt,
                     tab_exp[next_row]);
            end
            default: begin
               @(posedge clk);
               #1;
               i_gpio_in = tab_dat[next_row];
            end
         endcase
         next_row++;
      end
   endtask

   task automatic wait_irq(input string name, input bit from_timer, input logic level);
      int   cnt;
      logic cur;
      cnt = 0;
      cur = from_timer ? o_timer_irq : o_gpio_irq;
      while (cur !== level && cnt < TIMEOUT) begin
         @(posedge clk);
         #1;
         cur = from_timer ? o_timer_irq : o_gpio_irq;
         cnt++;
      end
      if (cur !== level) begin
         n_errors++;
         $display("Timeout at %0t: %s never went to %b", $time, name, level);
      end
   endtask

   // ********************
   // Main sequence
   // ********************

   initial begin
      wb_dat_t nmi_val;
      wb_dat_t out_val;
      wb_dat_t oe_val;
      wb_dat_t t0;
      wb_dat_t t1;
      wb_dat_t rdt;
      logic    ack;
      logic    err;

      nmi_val          = $urandom(32'h676d);
      clk              = 1'b0;
      i_rst_n          = 1'b0;
      i_wb_adr         = '0;
      i_wb_dat         = '0;
      i_wb_we          = 1'b0;
      i_wb_cyc         = 1'b0;
      i_wb_stb         = 1'b0;
      i_ram_init_done  = 1'b1;
      i_ram_init_error = 1'b0;
      i_gpio_in        = '0;
      n_rows           = 0;
      next_row         = 0;
      n_checks         = 0;
      n_errors         = 0;

      repeat (5) @(posedge clk);
      #1;
      i_rst_n = 1'b1;
      @(posedge clk);
      #1;

      // Outputs out of reset
      check("o_wb_ack", 32'(o_wb_ack), 32'd0);
      check("o_wb_err", 32'(o_wb_err), 32'd0);
      check("o_timer_irq", 32'(o_timer_irq), 32'd0);
      check("o_sw_irq3", 32'(o_sw_irq3), 32'd0);
      check("o_sw_irq4", 32'(o_sw_irq4), 32'd0);
      check("o_nmi_int", 32'(o_nmi_int), 32'd0);
      check("o_gpio_irq", 32'(o_gpio_irq), 32'd0);
      check("o_gpio_oe", o_gpio_oe, 32'd0);
      check("o_gpio_out", o_gpio_out, 32'd0);

      add_row(OP_RD, sys_addr(SYS_VERSION_OFS), '0, 32'h0001_0003);
      add_row(OP_RD, sys_addr(SYS_STATUS_OFS), '0, 32'h0000_0001);
      run_rows();
      i_ram_init_done  = 1'b0;
      i_ram_init_error = 1'b1;
      add_row(OP_RD, sys_addr(SYS_STATUS_OFS), '0, 32'h0000_0002);
      run_rows();
      i_ram_init_done  = 1'b1;
      i_ram_init_error = 1'b0;

      // Read-write registers with random data
      out_val = $urandom();
      oe_val  = $urandom();
      add_row(OP_WR, sys_addr(SYS_NMIVEC_OFS), nmi_val, '0);
      add_row(OP_WR, gpio_addr(GPIO_OUT_OFS), out_val, '0);
      add_row(OP_WR, gpio_addr(GPIO_OE_OFS), oe_val, '0);
      add_row(OP_RD, sys_addr(SYS_NMIVEC_OFS), '0, nmi_val);
      add_row(OP_RD, gpio_addr(GPIO_OUT_OFS), '0, out_val);
      add_row(OP_RD, gpio_addr(GPIO_OE_OFS), '0, oe_val);
      add_row(OP_WR, sys_addr(SYS_SWCTL_OFS), 32'hFFFF_FFF5, '0);
      add_row(OP_RD, sys_addr(SYS_SWCTL_OFS), '0, 32'h0000_0005);
      run_rows();
      check("o_nmi_vec", o_nmi_vec, nmi_val);
      check("o_gpio_out", o_gpio_out, out_val);
      check("o_gpio_oe", o_gpio_oe, oe_val);
      check("o_sw_irq3", 32'(o_sw_irq3), 32'd1);
      check("o_sw_irq4", 32'(o_sw_irq4), 32'd0);
      check("o_nmi_int", 32'(o_nmi_int), 32'd1);
      add_row(OP_WR, sys_addr(SYS_SWCTL_OFS), 32'h0000_0002, '0);
      run_rows();
      check("o_sw_irq3", 32'(o_sw_irq3), 32'd0);
      check("o_sw_irq4", 32'(o_sw_irq4), 32'd1);
      check("o_nmi_int", 32'(o_nmi_int), 32'd0);
      add_row(OP_WR, sys_addr(SYS_SWCTL_OFS), 32'h0000_0000, '0);
      add_row(OP_RD, sys_addr(SYS_SWCTL_OFS), '0, 32'h0000_0000);
      run_rows();

      // Unmapped region answers with err only
      bus_xfer(1'b1, UNMAPPED_ADR, $urandom(), rdt, ack, err);
      check("o_wb_err on write", 32'(err), 32'd1);
      check("o_wb_ack on write", 32'(ack), 32'd0);
      // Low bits land on writable offsets of both slaves
      bus_xfer(1'b1, UNMAPPED_ADR | wb_adr_t'(SYS_NMIVEC_OFS), ~nmi_val, rdt, ack, err);
      check("o_wb_err on write", 32'(err), 32'd1);
      bus_xfer(1'b1, UNMAPPED_ADR | wb_adr_t'(GPIO_OE_OFS), ~oe_val, rdt, ack, err);
      check("o_wb_err on write", 32'(err), 32'd1);
      bus_xfer(1'b0, UNMAPPED_ADR, '0, rdt, ack, err);
      check("o_wb_err on read", 32'(err), 32'd1);
      check("o_wb_ack on read", 32'(ack), 32'd0);
      check("o_wb_rdt on error", rdt, 32'd0);
      add_row(OP_RD, sys_addr(SYS_NMIVEC_OFS), '0, nmi_val);
      add_row(OP_RD, gpio_addr(GPIO_OUT_OFS), '0, out_val);
      add_row(OP_RD, gpio_addr(GPIO_OE_OFS), '0, oe_val);
      run_rows();

      // Machine timer
      bus_xfer(1'b0, sys_addr(SYS_MTIME_OFS), '0, t0, ack, err);
      bus_xfer(1'b0, sys_addr(SYS_MTIME_OFS), '0, t1, ack, err);
      check("mtime increasing", 32'(t1 > t0), 32'd1);
      add_row(OP_WR, sys_addr(SYS_MTIMECMP_OFS), 32'h0000_0040, '0);
      add_row(OP_RD, sys_addr(SYS_MTIMECMP_OFS), '0, 32'h0000_0040);
      run_rows();
      wait_irq("o_timer_irq", 1'b1, 1'b1);
      add_row(OP_WR, sys_addr(SYS_MTIMECMP_OFS), 32'hFFFF_FFFF, '0);
      run_rows();
      wait_irq("o_timer_irq", 1'b1, 1'b0);

      // Edge on an unmasked pin is ignored
      add_row(OP_WR, gpio_addr(GPIO_MASK_OFS), 32'h0000_0020, '0);
      add_row(OP_PIN, '0, 32'h0000_0200, '0);
      run_rows();
      repeat (6) @(posedge clk);
      #1;
      check("o_gpio_irq", 32'(o_gpio_irq), 32'd0);
      add_row(OP_RD, gpio_addr(GPIO_STAT_OFS), '0, 32'h0000_0000);
      add_row(OP_RD, gpio_addr(GPIO_IN_OFS), '0, 32'h0000_0200);
      run_rows();

      // Masked edge, then write one to clear
      add_row(OP_PIN, '0, 32'h0000_0220, '0);
      run_rows();
      wait_irq("o_gpio_irq", 1'b0, 1'b1);
      add_row(OP_RD, gpio_addr(GPIO_STAT_OFS), '0, 32'h0000_0020);
      add_row(OP_RD, sys_addr(SYS_STATUS_OFS), '0, 32'h0000_0005);
      add_row(OP_WR, gpio_addr(GPIO_STAT_OFS), 32'h0000_0020, '0);
      add_row(OP_RD, gpio_addr(GPIO_STAT_OFS), '0, 32'h0000_0000);
      add_row(OP_RD, sys_addr(SYS_STATUS_OFS), '0, 32'h0000_0001);
      run_rows();
      check("o_gpio_irq", 32'(o_gpio_irq), 32'd0);

      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/gpio_block.sv */
// 32-bit GPIO block
// Output and output-enable registers, synchronized pin input and
// a masked rising-edge interrupt with write-one-to-clear status

`timescale 1ns/1ps
`default_nettype none

module gpio_block
   import wb_bus_pkg::*, soc_map_pkg::*;
(
   input  wire           clk,
   input  wire           i_rst_n,
   input  wire           i_stb,
   input  wire           i_we,
   input  wire reg_ofs_t i_ofs,
   input  wire wb_dat_t  i_dat,
   output wb_dat_t       o_rdt,
   output logic          o_ack,
   input  wire gpio_t    i_gpio_in,
   output gpio_t         o_gpio_out,
   output gpio_t         o_gpio_oe,
   output logic          o_gpio_irq
);

   reg_ofs_t word_ofs;
   logic     wr_en;
   logic     ack_q;
   wb_dat_t  rd_data;
   wb_dat_t  rdt_q;
   gpio_t    in_meta_q;
   gpio_t    in_sync_q;
   gpio_t    in_prev_q;
   gpio_t    rise;
   gpio_t    stat_clr;
   gpio_t    out_q;
   gpio_t    oe_q;
   gpio_t    mask_q;
   gpio_t    stat_q;

   assign word_ofs = {i_ofs[REG_OFS_W-1:2], 2'b00};
   assign wr_en    = i_stb & i_we & ~ack_q;

   // ********************
   // Pin input
   // ********************

   // Two sync stages, third stage for edge detect
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         in_meta_q <= '0;
         in_sync_q <= '0;
         in_prev_q <= '0;
      end else begin
         in_meta_q <= i_gpio_in;
         in_sync_q <= in_meta_q;
         in_prev_q <= in_sync_q;
      end
   end

   assign rise     = in_sync_q & ~in_prev_q & mask_q;
   assign stat_clr = (wr_en && word_ofs == GPIO_STAT_OFS) ? i_dat[GPIO_W-1:0] : '0;

   // ********************
   // Registers
   // ********************

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         out_q  <= '0;
         oe_q   <= '0;
         mask_q <= '0;
      end else if (wr_en) begin
         case (word_ofs)
            GPIO_OUT_OFS:  out_q  <= i_dat[GPIO_W-1:0];
            GPIO_OE_OFS:   oe_q   <= i_dat[GPIO_W-1:0];
            GPIO_MASK_OFS: mask_q <= i_dat[GPIO_W-1:0];
            default:       ;
         endcase
      end
   end

   // A new edge wins over a clear in the same cycle
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         stat_q <= '0;
      end else begin
         stat_q <= (stat_q & ~stat_clr) | rise;
      end
   end

   assign o_gpio_out = out_q;
   assign o_gpio_oe  = oe_q;
   assign o_gpio_irq = |stat_q;

   always_comb begin
      case (word_ofs)
         GPIO_IN_OFS:   rd_data = in_sync_q;
         GPIO_OUT_OFS:  rd_data = out_q;
         GPIO_OE_OFS:   rd_data = oe_q;
         GPIO_MASK_OFS: rd_data = mask_q;
         GPIO_STAT_OFS: rd_data = stat_q;
         default:       rd_data = '0;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= i_stb & ~ack_q;
      end
   end

   always_ff @(posedge clk) begin
      if (i_stb && !ack_q) begin
         rdt_q <= rd_data;
      end
   end

   assign o_ack = ack_q;
   assign o_rdt = rdt_q;

endmodule

`default_nettype wire

/* verilog/mtime_timer.sv */
// Machine timer
// Free-running time counter and a compare register that raises
// the timer interrupt once the count reaches it

`timescale 1ns/1ps
`default_nettype none

module mtime_timer
   import wb_bus_pkg::*, soc_map_pkg::*;
(
   input  wire          clk,
   input  wire          i_rst_n,
   input  wire          i_cmp_we,
   input  wire wb_dat_t i_cmp_dat,
   output wb_dat_t      o_mtime,
   output wb_dat_t      o_mtimecmp,
   output logic         o_timer_irq
);

   wb_dat_t mtime_q;
   wb_dat_t mtimecmp_q;
   logic    irq_q;

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mtime_q <= '0;
      end else begin
         mtime_q <= mtime_q + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mtimecmp_q <= MTIMECMP_RESET;
      end else if (i_cmp_we) begin
         mtimecmp_q <= i_cmp_dat;
      end
   end

   // Compare result shows one cycle later
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         irq_q <= 1'b0;
      end else begin
         irq_q <= (mtime_q >= mtimecmp_q);
      end
   end

   assign o_mtime     = mtime_q;
   assign o_mtimecmp  = mtimecmp_q;
   assign o_timer_irq = irq_q;

endmodule

`default_nettype wire

/* verilog/periph_top.sv */
// Peripheral subsystem top level
// A Wishbone slave port reaches the system controller and the
// GPIO block through the address decoder

`timescale 1ns/1ps
`default_nettype none

module periph_top
   import wb_bus_pkg::*, soc_map_pkg::*;
(
   input  wire          clk,
   input  wire          i_rst_n,
   // Wishbone slave port
   input  wire wb_adr_t i_wb_adr,
   input  wire wb_dat_t i_wb_dat,
   input  wire          i_wb_we,
   input  wire          i_wb_cyc,
   input  wire          i_wb_stb,
   output wire wb_dat_t o_wb_rdt,
   output wire          o_wb_ack,
   output wire          o_wb_err,
   // System controller
   input  wire          i_ram_init_done,
   input  wire          i_ram_init_error,
   output wire          o_timer_irq,
   output wire          o_sw_irq3,
   output wire          o_sw_irq4,
   output wire          o_nmi_int,
   output wire wb_dat_t o_nmi_vec,
   // GPIO pins, pads live on the board top level
   input  wire gpio_t   i_gpio_in,
   output wire gpio_t   o_gpio_out,
   output wire gpio_t   o_gpio_oe,
   output wire          o_gpio_irq
);

   logic     sys_stb;
   logic     gpio_stb;
   wb_dat_t  sys_rdt;
   wb_dat_t  gpio_rdt;
   logic     sys_ack;
   logic     gpio_ack;
   logic     gpio_irq;
   reg_ofs_t wb_ofs;

   assign wb_ofs     = i_wb_adr[REG_OFS_W-1:0];
   assign o_gpio_irq = gpio_irq;

   wb_addr_decode u_decode (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_wb_adr   (i_wb_adr),
      .i_wb_cyc   (i_wb_cyc),
      .i_wb_stb   (i_wb_stb),
      .o_sys_stb  (sys_stb),
      .o_gpio_stb (gpio_stb),
      .i_sys_rdt  (sys_rdt),
      .i_sys_ack  (sys_ack),
      .i_gpio_rdt (gpio_rdt),
      .i_gpio_ack (gpio_ack),
      .o_wb_rdt   (o_wb_rdt),
      .o_wb_ack   (o_wb_ack),
      .o_wb_err   (o_wb_err)
   );

   sys_con u_sys_con (
      .clk              (clk),
      .i_rst_n          (i_rst_n),
      .i_stb            (sys_stb),
      .i_we             (i_wb_we),
      .i_ofs            (wb_ofs),
      .i_dat            (i_wb_dat),
      .o_rdt            (sys_rdt),
      .o_ack            (sys_ack),
      .i_ram_init_done  (i_ram_init_done),
      .i_ram_init_error (i_ram_init_error),
      .i_gpio_irq       (gpio_irq),
      .o_timer_irq      (o_timer_irq),
      .o_sw_irq3        (o_sw_irq3),
      .o_sw_irq4        (o_sw_irq4),
      .o_nmi_int        (o_nmi_int),
      .o_nmi_vec        (o_nmi_vec)
   );

   gpio_block u_gpio (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_stb      (gpio_stb),
      .i_we       (i_wb_we),
      .i_ofs      (wb_ofs),
      .i_dat      (i_wb_dat),
      .o_rdt      (gpio_rdt),
      .o_ack      (gpio_ack),
      .i_gpio_in  (i_gpio_in),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe),
      .o_gpio_irq (gpio_irq)
   );

endmodule

`default_nettype wire

/* verilog/soc_map_pkg.sv */
// Peripheral address map
// Region bases, register offsets, reset values and field widths
// of the system controller and the GPIO block

`default_nettype none

package soc_map_pkg;

   import wb_bus_pkg::*;

   // ********************
   // Regions
   // ********************

   localparam wb_adr_t SYS_BASE     = 16'h0000;
   localparam wb_adr_t GPIO_BASE    = 16'h0100;
   // Address bits below this belong to the register offset
   localparam int      REGION_SHIFT = 6;

   // ********************
   // System controller
   // ********************

   localparam reg_ofs_t SYS_VERSION_OFS  = 6'h00;
   localparam reg_ofs_t SYS_STATUS_OFS   = 6'h04;
   localparam reg_ofs_t SYS_SWCTL_OFS    = 6'h08;
   localparam reg_ofs_t SYS_NMIVEC_OFS   = 6'h0C;
   localparam reg_ofs_t SYS_MTIME_OFS    = 6'h10;
   localparam reg_ofs_t SYS_MTIMECMP_OFS = 6'h14;

   localparam wb_dat_t SYS_VERSION    = 32'h0001_0003;
   localparam wb_dat_t NMI_VEC_RESET  = 32'h0000_0000;
   // Keeps the timer interrupt low out of reset
   localparam wb_dat_t MTIMECMP_RESET = '1;

   // Software control: irq3, irq4, NMI request
   localparam int SWCTL_W        = 3;
   localparam int SWCTL_IRQ3_BIT = 0;
   localparam int SWCTL_IRQ4_BIT = 1;
   localparam int SWCTL_NMI_BIT  = 2;

   // Status: init done, init error, GPIO irq pending
   localparam int STATUS_W = 3;

   // ********************
   // GPIO
   // ********************

   localparam reg_ofs_t GPIO_IN_OFS   = 6'h00;
   localparam reg_ofs_t GPIO_OUT_OFS  = 6'h04;
   localparam reg_ofs_t GPIO_OE_OFS   = 6'h08;
   localparam reg_ofs_t GPIO_MASK_OFS = 6'h0C;
   localparam reg_ofs_t GPIO_STAT_OFS = 6'h10;

   localparam int GPIO_W = 32;
   typedef logic [GPIO_W-1:0] gpio_t;

endpackage

`default_nettype wire

/* verilog/sys_con.sv */
// System controller
// Version and status words, software interrupt and NMI control,
// NMI vector, and access to the machine timer

`timescale 1ns/1ps
`default_nettype none

module sys_con
   import wb_bus_pkg::*, soc_map_pkg::*;
(
   input  wire           clk,
   input  wire           i_rst_n,
   input  wire           i_stb,
   input  wire           i_we,
   input  wire reg_ofs_t i_ofs,
   input  wire wb_dat_t  i_dat,
   output wb_dat_t       o_rdt,
   output logic          o_ack,
   input  wire           i_ram_init_done,
   input  wire           i_ram_init_error,
   input  wire           i_gpio_irq,
   output logic          o_timer_irq,
   output logic          o_sw_irq3,
   output logic          o_sw_irq4,
   output logic          o_nmi_int,
   output wb_dat_t       o_nmi_vec
);

   reg_ofs_t           word_ofs;
   logic               wr_en;
   logic               cmp_we;
   logic               ack_q;
   wb_dat_t            rd_data;
   wb_dat_t            rdt_q;
   logic [SWCTL_W-1:0] swctl_q;
   wb_dat_t            nmi_vec_q;
   wb_dat_t            mtime;
   wb_dat_t            mtimecmp;

   // Byte lanes inside the word are ignored
   assign word_ofs = {i_ofs[REG_OFS_W-1:2], 2'b00};
   // Writes land on the edge where ack rises
   assign wr_en    = i_stb & i_we & ~ack_q;
   assign cmp_we   = wr_en & (word_ofs == SYS_MTIMECMP_OFS);

   // ********************
   // Control registers
   // ********************

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         swctl_q   <= '0;
         nmi_vec_q <= NMI_VEC_RESET;
      end else if (wr_en) begin
         case (word_ofs)
            SYS_SWCTL_OFS:  swctl_q   <= i_dat[SWCTL_W-1:0];
            SYS_NMIVEC_OFS: nmi_vec_q <= i_dat;
            default:        ;
         endcase
      end
   end

   assign o_sw_irq3 = swctl_q[SWCTL_IRQ3_BIT];
   assign o_sw_irq4 = swctl_q[SWCTL_IRQ4_BIT];
   assign o_nmi_int = swctl_q[SWCTL_NMI_BIT];
   assign o_nmi_vec = nmi_vec_q;

   mtime_timer u_mtime (
      .clk         (clk),
      .i_rst_n     (i_rst_n),
      .i_cmp_we    (cmp_we),
      .i_cmp_dat   (i_dat),
      .o_mtime     (mtime),
      .o_mtimecmp  (mtimecmp),
      .o_timer_irq (o_timer_irq)
   );

   // ********************
   // Read and ack
   // ********************

   always_comb begin
      case (word_ofs)
         SYS_VERSION_OFS:  rd_data = SYS_VERSION;
         SYS_STATUS_OFS:   rd_data = {{(WB_DAT_W-STATUS_W){1'b0}},
                                      i_gpio_irq, i_ram_init_error, i_ram_init_done};
         SYS_SWCTL_OFS:    rd_data = {{(WB_DAT_W-SWCTL_W){1'b0}}, swctl_q};
         SYS_NMIVEC_OFS:   rd_data = nmi_vec_q;
         SYS_MTIME_OFS:    rd_data = mtime;
         SYS_MTIMECMP_OFS: rd_data = mtimecmp;
         default:          rd_data = '0;
      endcase
   end

   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= i_stb & ~ack_q;
      end
   end

   always_ff @(posedge clk) begin
      if (i_stb && !ack_q) begin
         rdt_q <= rd_data;
      end
   end

   assign o_ack = ack_q;
   assign o_rdt = rdt_q;

   // Host releases the strobe once it has seen ack
   a_stb_released : assert property (@(posedge clk) disable iff (!i_rst_n)
      o_ack |-> !i_stb);

endmodule

`default_nettype wire

/* verilog/wb_addr_decode.sv */
// Wishbone address decoder
// Routes the strobe to the slave whose region matches, steers the
// reply back and answers unmapped addresses with an error

`timescale 1ns/1ps
`default_nettype none

module wb_addr_decode
   import wb_bus_pkg::*, soc_map_pkg::*;
(
   input  wire          clk,
   input  wire          i_rst_n,
   input  wire wb_adr_t i_wb_adr,
   input  wire          i_wb_cyc,
   input  wire          i_wb_stb,
   output logic         o_sys_stb,
   output logic         o_gpio_stb,
   input  wire wb_dat_t i_sys_rdt,
   input  wire          i_sys_ack,
   input  wire wb_dat_t i_gpio_rdt,
   input  wire          i_gpio_ack,
   output wb_dat_t      o_wb_rdt,
   output logic         o_wb_ack,
   output logic         o_wb_err
);

   localparam int REGION_W = WB_ADR_W - REGION_SHIFT;

   logic [REGION_W-1:0] adr_region;
   logic                req;
   logic                sys_hit;
   logic                gpio_hit;
   logic                miss;
   logic                sel_sys_q;
   logic                sel_gpio_q;
   logic                err_q;

   // ********************
   // Region match
   // ********************

   assign req        = i_wb_cyc & i_wb_stb;
   assign adr_region = i_wb_adr[WB_ADR_W-1:REGION_SHIFT];
   assign sys_hit    = (adr_region == SYS_BASE[WB_ADR_W-1:REGION_SHIFT]);
   assign gpio_hit   = (adr_region == GPIO_BASE[WB_ADR_W-1:REGION_SHIFT]);
   assign miss       = req & ~sys_hit & ~gpio_hit;

   assign o_sys_stb  = req & sys_hit;
   assign o_gpio_stb = req & gpio_hit;

   // ********************
   // Reply path
   // ********************

   // Selection lines up with the slave's registered ack
   always_ff @(posedge clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         sel_sys_q  <= 1'b0;
         sel_gpio_q <= 1'b0;
         err_q      <= 1'b0;
      end else begin
         sel_sys_q  <= o_sys_stb;
         sel_gpio_q <= o_gpio_stb;
         // One-cycle error, not repeated while the host still holds stb
         err_q      <= miss & ~err_q;
      end
   end

   always_comb begin
      if (sel_sys_q) begin
         o_wb_rdt = i_sys_rdt;
      end else if (sel_gpio_q) begin
         o_wb_rdt = i_gpio_rdt;
      end else begin
         o_wb_rdt = '0;
      end
   end

   assign o_wb_ack = (sel_sys_q & i_sys_ack) | (sel_gpio_q & i_gpio_ack);
   assign o_wb_err = err_q;

   // Error reply and slave ack must never collide
   a_ack_err_excl : assert property (@(posedge clk) disable iff (!i_rst_n)
      !((i_sys_ack || i_gpio_ack) && o_wb_err));

   // Only one slave replies at a time
   a_reply_excl : assert property (@(posedge clk) disable iff (!i_rst_n)
      !(i_sys_ack && i_gpio_ack));

endmodule

`default_nettype wire

/* verilog/wb_bus_pkg.sv */
// Wishbone slave port definitions
// Address and data widths plus the vector types that carry them

`default_nettype none

package wb_bus_pkg;

   // ********************
   // Port widths
   // ********************

   // Byte address, bits 1:0 ignored
   localparam int WB_ADR_W = 16;
   localparam int WB_DAT_W = 32;

   // One peripheral region spans 64 bytes
   localparam int REG_OFS_W = 6;

   // ********************
   // Vector types
   // ********************

   typedef logic [WB_ADR_W-1:0]  wb_adr_t;
   typedef logic [WB_DAT_W-1:0]  wb_dat_t;
   typedef logic [REG_OFS_W-1:0] reg_ofs_t;

endpackage

`default_nettype wire
